/* ex_defines.svh */
// --------------------
// Width macros for the execute stage
// Included by the packages and by every RTL file that sizes a port
// --------------------
`ifndef EX_DEFINES_SVH
`define EX_DEFINES_SVH

// Data and address width
`define EX_XLEN 32

// Scoreboard transaction id
`define EX_TRANS_ID_BITS 3

// Address space id of an SFENCE.VMA
`define EX_ASID_WIDTH 4

// CSR address field
`define EX_CSR_ADDR_BITS 12

`endif

/* fu_pkg.sv */
// --------------------
// Operation encoding and issued-instruction type of the functional units
// --------------------
`include "ex_defines.svh"

package fu_pkg;

    // Operations understood by the fixed latency units
    typedef enum logic [4:0] {
        // ALU
        ADD, SUB, AND, OR, XOR, SLL, SRL, SRA, SLT, SLTU,
        // Branch unit
        BEQ, BNE, BLT, BGE, BLTU, BGEU, JALR,
        // CSR buffer
        CSR_WRITE, SFENCE_VMA,
        // Multiplier
        MUL, MULH, MULHU
    } fu_op_e;

    // One issued instruction with its operands
    typedef struct packed {
        fu_op_e                         operation;
        logic [`EX_XLEN-1:0]            operand_a;
        logic [`EX_XLEN-1:0]            operand_b;
        logic [`EX_XLEN-1:0]            imm;
        logic [`EX_TRANS_ID_BITS-1:0]   trans_id;
    } fu_data_t;

endpackage

/* bp_pkg.sv */
// --------------------
// Branch prediction and branch resolution types
// --------------------
`include "ex_defines.svh"

package bp_pkg;

    // Prediction made by the frontend
    typedef struct packed {
        logic                   taken;
        logic [`EX_XLEN-1:0]    target;
    } bp_predict_t;

    // Outcome sent back to the frontend
    typedef struct packed {
        logic                   valid;
        logic                   taken;
        logic [`EX_XLEN-1:0]    target;
        logic                   mispredict;
    } bp_resolve_t;

endpackage

/* fu_issue_if.sv */
// --------------------
// Issue bus from the execute stage top level to the fixed latency units
// --------------------
`timescale 1ns/1ns

interface fu_issue_if (
    input logic clk_i,
    input logic rst_ni
);
    import fu_pkg::*;

    fu_data_t   fu_data;
    logic       alu_valid;
    logic       branch_valid;
    logic       csr_valid;
    logic       mult_valid;
    logic       flush;

    modport source (
        output fu_data, alu_valid, branch_valid, csr_valid, mult_valid, flush
    );

    modport sink (
        input fu_data, alu_valid, branch_valid, csr_valid, mult_valid, flush
    );

    // Only one unit may own the shared issue port in a cycle
    a_one_strobe: assert property (@(posedge clk_i) disable iff (!rst_ni)
        $onehot0({alu_valid, branch_valid, csr_valid, mult_valid}))
        else $error("more than one unit strobe raised");

endinterface

/* alu.sv */
// --------------------
// Single cycle ALU, also provides the comparison for conditional branches
// --------------------
`timescale 1ns/1ns
`include "ex_defines.svh"

module alu (
    fu_issue_if.sink                issue,
    output logic [`EX_XLEN-1:0]     result_o,
    output logic                    branch_res_o
);
    import fu_pkg::*;

    logic [`EX_XLEN-1:0]    op_a;
    logic [`EX_XLEN-1:0]    op_b;
    logic [4:0]             shamt;
    logic                   less_signed;
    logic                   less_unsigned;

    assign op_a  = issue.fu_data.operand_a;
    assign op_b  = issue.fu_data.operand_b;
    assign shamt = op_b[4:0];

    // Shared comparators for SLT and the branches
    assign less_signed   = $signed(op_a) < $signed(op_b);
    assign less_unsigned = op_a < op_b;

    // --------------------
    // Result
    // --------------------
    always_comb begin
        result_o = '0;
        case (issue.fu_data.operation)
            ADD:     result_o = op_a + op_b;
            SUB:     result_o = op_a - op_b;
            AND:     result_o = op_a & op_b;
            OR:      result_o = op_a | op_b;
            XOR:     result_o = op_a ^ op_b;
            SLL:     result_o = op_a << shamt;
            SRL:     result_o = op_a >> shamt;
            SRA:     result_o = $unsigned($signed(op_a) >>> shamt);
            SLT:     result_o = {{(`EX_XLEN-1){1'b0}}, less_signed};
            SLTU:    result_o = {{(`EX_XLEN-1){1'b0}}, less_unsigned};
            default: result_o = '0;
        endcase
    end

    // --------------------
    // Branch comparison
    // --------------------
    always_comb begin
        case (issue.fu_data.operation)
            BEQ:     branch_res_o = (op_a == op_b);
            BNE:     branch_res_o = (op_a != op_b);
            BLT:     branch_res_o = less_signed;
            BGE:     branch_res_o = ~less_signed;
            BLTU:    branch_res_o = less_unsigned;
            BGEU:    branch_res_o = ~less_unsigned;
            // Jumps are always taken
            default: branch_res_o = 1'b1;
        endcase
    end

endmodule

/* branch_unit.sv */
// --------------------
// Resolves conditional branches and JALR against the fetch prediction
// --------------------
`timescale 1ns/1ns
`include "ex_defines.svh"

module branch_unit (
    fu_issue_if.sink                issue,
    input  logic [`EX_XLEN-1:0]     pc_i,
    input  bp_pkg::bp_predict_t     predict_i,
    input  logic                    branch_res_i,
    output logic [`EX_XLEN-1:0]     link_o,
    output bp_pkg::bp_resolve_t     resolve_o
);
    import fu_pkg::*;

    logic                   is_jalr;
    logic [`EX_XLEN-1:0]    jump_base;
    logic [`EX_XLEN-1:0]    jump_addr;
    logic [`EX_XLEN-1:0]    next_pc;
    logic                   taken;
    logic [`EX_XLEN-1:0]    target;
    logic                   dir_wrong;
    logic                   target_wrong;

    assign is_jalr = (issue.fu_data.operation == JALR);

    // No compressed instructions, fall-through is always four bytes on
    assign next_pc = pc_i + `EX_XLEN'd4;
    assign link_o  = next_pc;

    // JALR jumps relative to rs1, branches relative to the PC
    assign jump_base = is_jalr ? issue.fu_data.operand_a : pc_i;
    assign jump_addr = (jump_base + issue.fu_data.imm)
                     & {{(`EX_XLEN-1){1'b1}}, ~is_jalr};

    assign taken  = is_jalr | branch_res_i;
    assign target = taken ? jump_addr : next_pc;

    // --------------------
    // Misprediction check
    // --------------------
    assign dir_wrong    = (taken != predict_i.taken);
    assign target_wrong = taken & predict_i.taken & (target != predict_i.target);

    assign resolve_o.valid      = issue.branch_valid;
    assign resolve_o.taken      = taken;
    assign resolve_o.target     = target;
    assign resolve_o.mispredict = issue.branch_valid & (dir_wrong | target_wrong);

endmodule

/* csr_buffer.sv */
// --------------------
// Single-entry buffer for CSR writes and SFENCE.VMA operands
// Holds the entry until commit and blocks further CSR issue while full
// --------------------
`timescale 1ns/1ns
`include "ex_defines.svh"

module csr_buffer (
    input  logic                            clk_i,
    input  logic                            rst_ni,
    fu_issue_if.sink                        issue,
    input  logic                            csr_commit_i,
    output logic                            ready_o,
    output logic [`EX_XLEN-1:0]             csr_result_o,
    output logic [`EX_CSR_ADDR_BITS-1:0]    csr_addr_o,
    output logic                            tlb_flush_o,
    output logic [`EX_XLEN-1:0]             flush_vaddr_o,
    output logic [`EX_ASID_WIDTH-1:0]       flush_asid_o
);
    import fu_pkg::*;

    logic                           full_q;
    logic                           is_fence_q;
    logic [`EX_CSR_ADDR_BITS-1:0]   csr_addr_q;
    logic [`EX_XLEN-1:0]            vaddr_q;
    logic [`EX_ASID_WIDTH-1:0]      asid_q;
    logic                           issue_csr;
    logic                           issue_fence;

    assign issue_csr   = issue.csr_valid & (issue.fu_data.operation == CSR_WRITE);
    assign issue_fence = issue.csr_valid & (issue.fu_data.operation == SFENCE_VMA);

    // --------------------
    // Entry state
    // --------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            full_q     <= 1'b0;
            is_fence_q <= 1'b0;
        end else if (issue.flush) begin
            full_q     <= 1'b0;
            is_fence_q <= 1'b0;
        end else if (issue.csr_valid) begin
            full_q     <= 1'b1;
            is_fence_q <= issue_fence;
        end else if (csr_commit_i) begin
            full_q     <= 1'b0;
            is_fence_q <= 1'b0;
        end
    end

    // Payload, only loaded on issue
    always_ff @(posedge clk_i) begin
        if (issue_csr) begin
            csr_addr_q <= issue.fu_data.imm[`EX_CSR_ADDR_BITS-1:0];
        end
        if (issue_fence) begin
            vaddr_q <= issue.fu_data.operand_a;
            asid_q  <= issue.fu_data.operand_b[`EX_ASID_WIDTH-1:0];
        end
    end

    assign ready_o       = ~full_q;
    // Write value goes straight to the scoreboard
    assign csr_result_o  = issue.fu_data.operand_a;
    assign csr_addr_o    = csr_addr_q;
    assign tlb_flush_o   = csr_commit_i & full_q & is_fence_q;
    assign flush_vaddr_o = vaddr_q;
    assign flush_asid_o  = asid_q;

    // Issue logic has to honour ready_o from the previous cycle
    a_no_issue_when_full: assert property (@(posedge clk_i) disable iff (!rst_ni)
        issue.csr_valid |-> !full_q)
        else $error("CSR issued while the buffer is full");

endmodule

/* mult.sv */
// --------------------
// One-stage pipelined 32x32 multiplier for MUL, MULH and MULHU
// --------------------
`timescale 1ns/1ns
`include "ex_defines.svh"

module mult (
    input  logic                            clk_i,
    input  logic                            rst_ni,
    fu_issue_if.sink                        issue,
    output logic [`EX_XLEN-1:0]             result_o,
    output logic                            valid_o,
    output logic [`EX_TRANS_ID_BITS-1:0]    trans_id_o
);
    import fu_pkg::*;

    logic [`EX_XLEN-1:0]            op_a;
    logic [`EX_XLEN-1:0]            op_b;
    logic [2*`EX_XLEN-1:0]          prod_signed;
    logic [2*`EX_XLEN-1:0]          prod_unsigned;
    logic [`EX_XLEN-1:0]            result_d;
    logic [`EX_XLEN-1:0]            result_q;
    logic [`EX_TRANS_ID_BITS-1:0]   trans_id_q;
    logic                           valid_q;

    assign op_a = issue.fu_data.operand_a;
    assign op_b = issue.fu_data.operand_b;

    // Full width products of the sign or zero extended operands
    assign prod_signed = $signed({{`EX_XLEN{op_a[`EX_XLEN-1]}}, op_a})
                       * $signed({{`EX_XLEN{op_b[`EX_XLEN-1]}}, op_b});
    assign prod_unsigned = {{`EX_XLEN{1'b0}}, op_a} * {{`EX_XLEN{1'b0}}, op_b};

    always_comb begin
        case (issue.fu_data.operation)
            MULH:    result_d = prod_signed[2*`EX_XLEN-1:`EX_XLEN];
            MULHU:   result_d = prod_unsigned[2*`EX_XLEN-1:`EX_XLEN];
            default: result_d = prod_unsigned[`EX_XLEN-1:0];
        endcase
    end

    // --------------------
    // Output stage
    // --------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= issue.mult_valid & ~issue.flush;
        end
    end

    always_ff @(posedge clk_i) begin
        if (issue.mult_valid) begin
            result_q   <= result_d;
            trans_id_q <= issue.fu_data.trans_id;
        end
    end

    assign result_o   = result_q;
    assign valid_o    = valid_q;
    assign trans_id_o = trans_id_q;

    // The write-back slot of a result belongs to the multiplier
    a_result_slot: assert property (@(posedge clk_i) disable iff (!rst_ni)
        valid_o |-> !(issue.alu_valid || issue.branch_valid || issue.csr_valid))
        else $error("ALU, branch or CSR issue collides with a multiplier result");

endmodule

/* ex_stage.sv */
// --------------------
// Execute stage top level with ALU, branch unit, CSR buffer and multiplier
// All units share one issue port and one write-back port
// --------------------
`timescale 1ns/1ns
`include "ex_defines.svh"

module ex_stage (
    input  logic                            clk_i,
    input  logic                            rst_ni,
    input  logic                            flush_i,
    // Issue
    input  fu_pkg::fu_op_e                  operation_i,
    input  logic [`EX_XLEN-1:0]             operand_a_i,
    input  logic [`EX_XLEN-1:0]             operand_b_i,
    input  logic [`EX_XLEN-1:0]             imm_i,
    input  logic [`EX_TRANS_ID_BITS-1:0]    trans_id_i,
    input  logic [`EX_XLEN-1:0]             pc_i,
    input  logic                            alu_valid_i,
    input  logic                            branch_valid_i,
    input  logic                            csr_valid_i,
    input  logic                            mult_valid_i,
    input  logic                            predict_taken_i,
    input  logic [`EX_XLEN-1:0]             predict_target_i,
    input  logic                            csr_commit_i,
    // Write-back
    output logic [`EX_XLEN-1:0]             flu_result_o,
    output logic [`EX_TRANS_ID_BITS-1:0]    flu_trans_id_o,
    output logic                            flu_valid_o,
    output logic                            flu_ready_o,
    // Branch resolution
    output logic                            resolve_branch_o,
    output logic                            resolved_taken_o,
    output logic [`EX_XLEN-1:0]             resolved_target_o,
    output logic                            mispredict_o,
    // CSR and TLB flush
    output logic [`EX_CSR_ADDR_BITS-1:0]    csr_addr_o,
    output logic                            tlb_flush_o,
    output logic [`EX_XLEN-1:0]             flush_vaddr_o,
    output logic [`EX_ASID_WIDTH-1:0]       flush_asid_o
);
    import bp_pkg::*;

    logic [`EX_XLEN-1:0]            alu_result;
    logic                           alu_branch_res;
    logic [`EX_XLEN-1:0]            link_addr;
    logic [`EX_XLEN-1:0]            csr_result;
    logic [`EX_XLEN-1:0]            mult_result;
    logic                           mult_valid;
    logic [`EX_TRANS_ID_BITS-1:0]   mult_trans_id;
    bp_predict_t                    predict;
    bp_resolve_t                    resolve;

    // --------------------
    // Issue bus
    // --------------------
    fu_issue_if i_issue (
        .clk_i  (clk_i),
        .rst_ni (rst_ni)
    );

    assign i_issue.fu_data.operation = operation_i;
    assign i_issue.fu_data.operand_a = operand_a_i;
    assign i_issue.fu_data.operand_b = operand_b_i;
    assign i_issue.fu_data.imm       = imm_i;
    assign i_issue.fu_data.trans_id  = trans_id_i;
    assign i_issue.alu_valid         = alu_valid_i;
    assign i_issue.branch_valid      = branch_valid_i;
    assign i_issue.csr_valid         = csr_valid_i;
    assign i_issue.mult_valid        = mult_valid_i;
    assign i_issue.flush             = flush_i;

    assign predict.taken  = predict_taken_i;
    assign predict.target = predict_target_i;

    // --------------------
    // Functional units
    // --------------------
    alu i_alu (
        .issue        (i_issue),
        .result_o     (alu_result),
        .branch_res_o (alu_branch_res)
    );

    branch_unit i_branch_unit (
        .issue        (i_issue),
        .pc_i         (pc_i),
        .predict_i    (predict),
        .branch_res_i (alu_branch_res),
        .link_o       (link_addr),
        .resolve_o    (resolve)
    );

    csr_buffer i_csr_buffer (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .issue         (i_issue),
        .csr_commit_i  (csr_commit_i),
        .ready_o       (flu_ready_o),
        .csr_result_o  (csr_result),
        .csr_addr_o    (csr_addr_o),
        .tlb_flush_o   (tlb_flush_o),
        .flush_vaddr_o (flush_vaddr_o),
        .flush_asid_o  (flush_asid_o)
    );

    mult i_mult (
        .clk_i      (clk_i),
        .rst_ni     (rst_ni),
        .issue      (i_issue),
        .result_o   (mult_result),
        .valid_o    (mult_valid),
        .trans_id_o (mult_trans_id)
    );

    // --------------------
    // Write-back mux
    // --------------------
    assign flu_valid_o = alu_valid_i | branch_valid_i | csr_valid_i | mult_valid;

    always_comb begin
        // Link address when nothing else writes back
        flu_result_o   = link_addr;
        flu_trans_id_o = trans_id_i;
        if (alu_valid_i) begin
            flu_result_o = alu_result;
        end else if (csr_valid_i) begin
            flu_result_o = csr_result;
        end else if (mult_valid) begin
            flu_result_o   = mult_result;
            flu_trans_id_o = mult_trans_id;
        end
    end

    assign resolve_branch_o  = resolve.valid;
    assign resolved_taken_o  = resolve.taken;
    assign resolved_target_o = resolve.target;
    assign mispredict_o      = resolve.mispredict;

endmodule

/* tb_ex_stage.sv */
// --------------------
// Self-checking testbench for the execute stage
// Random stimulus against a reference model, one report line per test
// --------------------
`timescale 1ns/1ns
`include "ex_defines.svh"

module tb_ex_stage;
    import fu_pkg::*;

    localparam int CLK_PERIOD   = 4;
    localparam int ALU_OPS      = 200;
    localparam int BRANCH_OPS   = 100;
    localparam int MULT_OPS     = 64;
    localparam int CSR_ROUNDS   = 8;
    // Reset, idle cycles between tests, four cycles per buffer round
    localparam int TOTAL_CYCLES = 12 + ALU_OPS + BRANCH_OPS + MULT_OPS + 8 * CSR_ROUNDS;
    localparam int MARGIN_NS    = 200;

    logic                           clk;
    logic                           rst_n;
    logic                           flush;
    fu_op_e                         operation;
    logic [`EX_XLEN-1:0]            operand_a;
    logic [`EX_XLEN-1:0]            operand_b;
    logic [`EX_XLEN-1:0]            imm;
    logic [`EX_TRANS_ID_BITS-1:0]   trans_id;
    logic [`EX_XLEN-1:0]            pc;
    logic                           alu_valid;
    logic                           branch_valid;
    logic                           csr_valid;
    logic                           mult_valid;
    logic                           predict_taken;
    logic [`EX_XLEN-1:0]            predict_target;
    logic                           csr_commit;
    logic [`EX_XLEN-1:0]            flu_result;
    logic [`EX_TRANS_ID_BITS-1:0]   flu_trans_id;
    logic                           flu_valid;
    logic                           flu_ready;
    logic                           resolve_branch;
    logic                           resolved_taken;
    logic [`EX_XLEN-1:0]            resolved_target;
    logic                           mispredict;
    logic [`EX_CSR_ADDR_BITS-1:0]   csr_addr;
    logic                           tlb_flush;
    logic [`EX_XLEN-1:0]            flush_vaddr;
    logic [`EX_ASID_WIDTH-1:0]      flush_asid;

    integer                         seed;
    int                             tests;
    int                             checks;
    int                             errors;
    int                             start_checks;
    int                             start_errors;
    string                          test_name;
    logic                           exp_taken;
    logic [`EX_XLEN-1:0]            exp_target;
    logic [`EX_XLEN-1:0]            exp_prod;
    logic [`EX_TRANS_ID_BITS-1:0]   exp_id;

    ex_stage i_dut (
        .clk_i             (clk),
        .rst_ni            (rst_n),
        .flush_i           (flush),
        .operation_i       (operation),
        .operand_a_i       (operand_a),
        .operand_b_i       (operand_b),
        .imm_i             (imm),
        .trans_id_i        (trans_id),
        .pc_i              (pc),
        .alu_valid_i       (alu_valid),
        .branch_valid_i    (branch_valid),
        .csr_valid_i       (csr_valid),
        .mult_valid_i      (mult_valid),
        .predict_taken_i   (predict_taken),
        .predict_target_i  (predict_target),
        .csr_commit_i      (csr_commit),
        .flu_result_o      (flu_result),
        .flu_trans_id_o    (flu_trans_id),
        .flu_valid_o       (flu_valid),
        .flu_ready_o       (flu_ready),
        .resolve_branch_o  (resolve_branch),
        .resolved_taken_o  (resolved_taken),
        .resolved_target_o (resolved_target),
        .mispredict_o      (mispredict),
        .csr_addr_o        (csr_addr),
        .tlb_flush_o       (tlb_flush),
        .flush_vaddr_o     (flush_vaddr),
        .flush_asid_o      (flush_asid)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // --------------------
    // Reference model
    // --------------------
    function automatic logic [`EX_XLEN-1:0] alu_model(input fu_op_e op,
            input logic [`EX_XLEN-1:0] a, input logic [`EX_XLEN-1:0] b);
        case (op)
            ADD:     return a + b;
            SUB:     return a - b;
            AND:     return a & b;
            OR:      return a | b;
            XOR:     return a ^ b;
            SLL:     return a << b[4:0];
            SRL:     return a >> b[4:0];
            SRA:     return $signed(a) >>> b[4:0];
            SLT:     return ($signed(a) < $signed(b)) ? 1 : 0;
            SLTU:    return (a < b) ? 1 : 0;
            default: return 'x;
        endcase
    endfunction

    function automatic logic branch_cond(input fu_op_e op,
            input logic [`EX_XLEN-1:0] a, input logic [`EX_XLEN-1:0] b);
        case (op)
            BEQ:     return a == b;
            BNE:     return a != b;
            BLT:     return $signed(a) < $signed(b);
            BGE:     return $signed(a) >= $signed(b);
            BLTU:    return a < b;
            BGEU:    return a >= b;
            default: return 1'b1;
        endcase
    endfunction

    function automatic logic [`EX_XLEN-1:0] mult_model(input fu_op_e op,
            input logic [`EX_XLEN-1:0] a, input logic [`EX_XLEN-1:0] b);
        longint          prod_s;
        longint unsigned prod_u;
        prod_s = longint'($signed(a)) * longint'($signed(b));
        prod_u = longint'(a) * longint'(b);
        case (op)
            MULH:    return prod_s[63:32];
            MULHU:   return prod_u[63:32];
            default: return prod_u[31:0];
        endcase
    endfunction

    // --------------------
    // Helpers
    // --------------------
    function automatic logic [`EX_XLEN-1:0] rand_word();
        return $random(seed);
    endfunction

    function automatic int rand_below(input int n);
        return $unsigned($random(seed)) % n;
    endfunction

    function automatic logic [`EX_TRANS_ID_BITS-1:0] rand_id();
        logic [`EX_XLEN-1:0] word;
        word = $random(seed);
        return word[`EX_TRANS_ID_BITS-1:0];
    endfunction

    task automatic compare(input string label, input logic [`EX_XLEN-1:0] expected,
            input logic [`EX_XLEN-1:0] actual);
        checks++;
        assert (actual === expected) else begin
            errors++;
            $display("** Error %s %s: expected 0x%08h, actual 0x%08h",
                     test_name, label, expected, actual);
        end
    endtask

    task automatic start_test(input string name);
        test_name    = name;
        start_checks = checks;
        start_errors = errors;
    endtask

    task automatic end_test();
        tests++;
        $display("test %-7s done: %0d checks, %0d errors",
                 test_name, checks - start_checks, errors - start_errors);
    endtask

    task automatic set_idle();
        alu_valid    = 1'b0;
        branch_valid = 1'b0;
        csr_valid    = 1'b0;
        mult_valid   = 1'b0;
        csr_commit   = 1'b0;
        flush        = 1'b0;
    endtask

    // One CSR write or SFENCE.VMA, released by commit or by flush
    task automatic buffer_round(input logic fence, input logic by_commit);
        @(negedge clk);
        set_idle();
        operation = fence ? SFENCE_VMA : CSR_WRITE;
        operand_a = rand_word();
        operand_b = rand_word();
        imm       = rand_word();
        trans_id  = rand_id();
        csr_valid = 1'b1;
        #1;
        compare("ready at issue", 1, flu_ready);
        compare("valid", 1, flu_valid);
        compare("trans_id", trans_id, flu_trans_id);
        if (!fence) begin
            compare("result", operand_a, flu_result);
        end
        @(negedge clk);
        set_idle();
        #1;
        compare("ready when full", 0, flu_ready);
        compare("tlb_flush early", 0, tlb_flush);
        if (!fence) begin
            compare("csr_addr", imm[`EX_CSR_ADDR_BITS-1:0], csr_addr);
        end
        @(negedge clk);
        csr_commit = by_commit;
        flush      = ~by_commit;
        #1;
        compare("ready at release", 0, flu_ready);
        compare("tlb_flush", fence & by_commit, tlb_flush);
        if (fence && by_commit) begin
            compare("vaddr", operand_a, flush_vaddr);
            compare("asid", operand_b[`EX_ASID_WIDTH-1:0], flush_asid);
        end
        @(negedge clk);
        set_idle();
        #1;
        compare("ready after release", 1, flu_ready);
        compare("tlb_flush late", 0, tlb_flush);
    endtask

    // --------------------
    // Tests
    // --------------------
    initial begin
        seed           = 23;
        tests          = 0;
        checks         = 0;
        errors         = 0;
        clk            = 1'b0;
        rst_n          = 1'b0;
        operation      = ADD;
        operand_a      = '0;
        operand_b      = '0;
        imm            = '0;
        trans_id       = '0;
        pc             = '0;
        predict_taken  = 1'b0;
        predict_target = '0;
        set_idle();
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        start_test("reset");
        #1;
        compare("flu_valid", 0, flu_valid);
        compare("resolve_branch", 0, resolve_branch);
        compare("tlb_flush", 0, tlb_flush);
        compare("flu_ready", 1, flu_ready);
        end_test();

        start_test("alu");
        for (int i = 0; i < ALU_OPS; i++) begin
            @(negedge clk);
            set_idle();
            operation = fu_op_e'(int'(ADD) + rand_below(10));
            operand_a = rand_word();
            operand_b = rand_word();
            trans_id  = rand_id();
            alu_valid = 1'b1;
            #1;
            compare("valid", 1, flu_valid);
            compare("result", alu_model(operation, operand_a, operand_b), flu_result);
            compare("trans_id", trans_id, flu_trans_id);
        end
        @(negedge clk);
        set_idle();
        end_test();

        start_test("branch");
        for (int i = 0; i < BRANCH_OPS; i++) begin
            @(negedge clk);
            set_idle();
            operation = fu_op_e'(int'(BEQ) + rand_below(7));
            operand_a = rand_word();
            // Equal operands now and then so BEQ and BGE get taken
            operand_b = (rand_below(4) == 0) ? operand_a : rand_word();
            imm       = rand_word();
            pc        = rand_word() & ~`EX_XLEN'd3;
            exp_taken = (operation == JALR) | branch_cond(operation, operand_a, operand_b);
            if (!exp_taken) begin
                exp_target = pc + 4;
            end else if (operation == JALR) begin
                exp_target = (operand_a + imm) & ~`EX_XLEN'd1;
            end else begin
                exp_target = pc + imm;
            end
            predict_taken  = (rand_below(2) == 1);
            predict_target = (rand_below(2) == 1) ? exp_target : rand_word();
            branch_valid   = 1'b1;
            #1;
            compare("resolve", 1, resolve_branch);
            compare("taken", exp_taken, resolved_taken);
            compare("target", exp_target, resolved_target);
            compare("mispredict", (exp_taken != predict_taken)
                    | (exp_taken & predict_taken & (exp_target != predict_target)), mispredict);
            compare("link", pc + 4, flu_result);
        end
        @(negedge clk);
        set_idle();
        end_test();

        start_test("mult");
        for (int i = 0; i <= MULT_OPS; i++) begin
            @(negedge clk);
            set_idle();
            if (i < MULT_OPS) begin
                operation  = fu_op_e'(int'(MUL) + rand_below(3));
                operand_a  = rand_word();
                operand_b  = rand_word();
                trans_id   = rand_id();
                mult_valid = 1'b1;
            end
            #1;
            if (i > 0) begin
                compare("valid", 1, flu_valid);
                compare("result", exp_prod, flu_result);
                compare("trans_id", exp_id, flu_trans_id);
            end
            exp_prod = mult_model(operation, operand_a, operand_b);
            exp_id   = trans_id;
        end
        @(negedge clk);
        #1;
        compare("valid after last", 0, flu_valid);
        end_test();

        start_test("csr");
        for (int i = 0; i < CSR_ROUNDS; i++) begin
            buffer_round(1'b0, i % 2 == 0);
        end
        end_test();

        start_test("sfence");
        for (int i = 0; i < CSR_ROUNDS; i++) begin
            buffer_round(1'b1, i % 2 == 0);
        end
        end_test();

        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

    // Watchdog sized from the test lengths
    initial begin
        #(TOTAL_CYCLES * CLK_PERIOD + MARGIN_NS);
        $display("Watchdog expired before all tests finished");
        $display("SIMULATION FAILED");
        $finish;
    end

endmodule

/* flist.f */
+incdir+.
fu_pkg.sv
bp_pkg.sv
fu_issue_if.sv
alu.sv
branch_unit.sv
csr_buffer.sv
mult.sv
ex_stage.sv
tb_ex_stage.sv
